/* pagerank_pkg.sv */
package pagerank_pkg;

	// Compute unit fan-out
	localparam int NUM_CU     = 4;
	localparam int CU_ID_BITS = $clog2(NUM_CU);

	// Buffer depths in entries
	localparam int JOB_BUFFER_DEPTH = 8;
	localparam int CMD_BUFFER_DEPTH = 8;

	// Payload widths
	localparam int VERTEX_BITS = 16;
	localparam int ADDR_BITS   = 32;
	localparam int DATA_BITS   = 32;
	localparam int COUNT_BITS  = 16;

	typedef logic [CU_ID_BITS-1:0]  cu_id_t;
	typedef logic [NUM_CU-1:0]      cu_mask_t;
	typedef logic [VERTEX_BITS-1:0] vertex_t;
	typedef logic [ADDR_BITS-1:0]   addr_t;
	typedef logic [DATA_BITS-1:0]   rsp_data_t;
	typedef logic [COUNT_BITS-1:0]  count_t;

	// First requester after last, wrapping; caller checks |req
	function automatic cu_id_t rr_pick(cu_mask_t req, cu_id_t last);
		cu_id_t pick;
		int idx;
		pick = last;
		for (int k = NUM_CU; k >= 1; k--) begin
			idx = (int'(last) + k) % NUM_CU;
			if (req[idx])
				pick = cu_id_t'(idx);
		end
		return pick;
	endfunction

endpackage

/* read_cmd_if.sv */
`timescale 1ns/1ps

// Arbitrated read commands into the burst buffer
interface read_cmd_if;

	logic                 valid;
	pagerank_pkg::cu_id_t cu_id;
	pagerank_pkg::addr_t  addr;

	// Buffer back-pressure, honoured by the arbiter
	logic                 alfull;

	modport arbiter (
		output valid,
		output cu_id,
		output addr,
		input  alfull
	);

	modport buffer (
		input  valid,
		input  cu_id,
		input  addr,
		output alfull
	);

endinterface

/* job_fifo.sv */
`timescale 1ns/1ps

module job_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 8
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             full,
	output logic             alfull,
	output logic             empty
);

	logic [WIDTH-1:0]           mem [DEPTH];
	logic [$clog2(DEPTH)-1:0]   wr_ptr;
	logic [$clog2(DEPTH)-1:0]   rd_ptr;
	logic [$clog2(DEPTH+1)-1:0] count;
	logic                       do_push;
	logic                       do_pop;

	// Overflow and underflow requests are dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign full     = (int'(count) == DEPTH);
	assign alfull   = ((DEPTH - int'(count)) <= 2);
	assign empty    = (count == '0);
	assign data_out = mem[rd_ptr];

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= data_in;
	end

endmodule

/* vertex_job_dispatch.sv */
`timescale 1ns/1ps

module vertex_job_dispatch (
	input  logic                                              clock,
	input  logic                                              rstn,
	input  logic                                              enabled,
	input  logic                                              job_valid,
	input  pagerank_pkg::vertex_t                             job_vertex,
	output logic                                              job_request,
	input  pagerank_pkg::cu_mask_t                            cu_job_request,
	output pagerank_pkg::cu_mask_t                            cu_job_valid,
	output pagerank_pkg::vertex_t [pagerank_pkg::NUM_CU-1:0]  cu_job_vertex
);

	logic                   buf_alfull;
	logic                   buf_empty;
	pagerank_pkg::vertex_t  buf_vertex;
	pagerank_pkg::cu_mask_t pending;
	pagerank_pkg::cu_id_t   last_grant;
	pagerank_pkg::cu_id_t   grant_id;
	pagerank_pkg::cu_mask_t grant;
	logic                   hand_out;

	job_fifo #(
		.WIDTH($bits(pagerank_pkg::vertex_t)),
		.DEPTH(pagerank_pkg::JOB_BUFFER_DEPTH)
	) job_buffer_i (
		.clock   (clock),
		.rstn    (rstn),
		.push    (job_valid),
		.data_in (job_vertex),
		.pop     (hand_out),
		.data_out(buf_vertex),
		.full    (),
		.alfull  (buf_alfull),
		.empty   (buf_empty)
	);

	// Next pending unit after the last one served
	assign grant_id = pagerank_pkg::rr_pick(pending, last_grant);
	assign grant    = pagerank_pkg::cu_mask_t'(1) << grant_id;
	assign hand_out = enabled && !buf_empty && (|pending);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_request  <= 1'b0;
			pending      <= '0;
			cu_job_valid <= '0;
			last_grant   <= pagerank_pkg::cu_id_t'(pagerank_pkg::NUM_CU - 1);
		end else begin
			job_request  <= !buf_alfull;
			// Served bit clears first so a fresh pulse is kept
			pending      <= (pending & ~(hand_out ? grant : '0)) | cu_job_request;
			cu_job_valid <= hand_out ? grant : '0;
			if (hand_out)
				last_grant <= grant_id;
		end
	end

	always_ff @(posedge clock) begin
		if (hand_out)
			cu_job_vertex[grant_id] <= buf_vertex;
	end

endmodule

/* read_cmd_arbiter.sv */
`timescale 1ns/1ps

module read_cmd_arbiter (
	input  logic                                            clock,
	input  logic                                            rstn,
	input  logic                                            enabled,
	input  pagerank_pkg::cu_mask_t                          cu_cmd_request,
	input  pagerank_pkg::addr_t [pagerank_pkg::NUM_CU-1:0]  cu_cmd_addr,
	output pagerank_pkg::cu_mask_t                          cu_cmd_ready,
	read_cmd_if.arbiter                                     cmd
);

	pagerank_pkg::cu_mask_t eligible;
	pagerank_pkg::cu_id_t   winner;
	pagerank_pkg::cu_id_t   last_grant;
	logic                   accept;

	//////////////////////////////////////////////////
	// Winner selection
	//////////////////////////////////////////////////

	// Unit served last cycle still holds its request for one edge
	assign eligible = cu_cmd_request & ~cu_cmd_ready;
	assign winner   = pagerank_pkg::rr_pick(eligible, last_grant);
	assign accept   = enabled && !cmd.alfull && (|eligible);

	//////////////////////////////////////////////////
	// Ready pulse and push into burst buffer
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_cmd_ready <= '0;
			cmd.valid    <= 1'b0;
			last_grant   <= pagerank_pkg::cu_id_t'(pagerank_pkg::NUM_CU - 1);
		end else begin
			cu_cmd_ready <= accept ? (pagerank_pkg::cu_mask_t'(1) << winner) : '0;
			cmd.valid    <= accept;
			if (accept)
				last_grant <= winner;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			cmd.cu_id <= winner;
			cmd.addr  <= cu_cmd_addr[winner];
		end
	end

endmodule

/* cmd_bus_issue.sv */
`timescale 1ns/1ps

module cmd_bus_issue (
	input  logic                 clock,
	input  logic                 rstn,
	input  logic                 enabled,
	read_cmd_if.buffer           cmd,
	input  logic                 mem_alfull,
	input  logic                 cmd_bus_grant,
	output logic                 cmd_bus_request,
	output logic                 cmd_out_valid,
	output pagerank_pkg::cu_id_t cmd_out_cu,
	output pagerank_pkg::addr_t  cmd_out_addr
);

	logic [$bits(pagerank_pkg::cu_id_t)+$bits(pagerank_pkg::addr_t)-1:0] buf_out;
	logic buf_empty;
	logic grant_q;
	logic mem_alfull_q;
	logic bus_pop;

	job_fifo #(
		.WIDTH($bits(pagerank_pkg::cu_id_t) + $bits(pagerank_pkg::addr_t)),
		.DEPTH(pagerank_pkg::CMD_BUFFER_DEPTH)
	) cmd_buffer_i (
		.clock   (clock),
		.rstn    (rstn),
		.push    (cmd.valid),
		.data_in ({cmd.cu_id, cmd.addr}),
		.pop     (bus_pop),
		.data_out(buf_out),
		.full    (),
		.alfull  (cmd.alfull),
		.empty   (buf_empty)
	);

	// Grant and back-pressure sampled on the same edge
	assign bus_pop = grant_q && !mem_alfull_q && !buf_empty;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			grant_q         <= 1'b0;
			mem_alfull_q    <= 1'b0;
			cmd_bus_request <= 1'b0;
			cmd_out_valid   <= 1'b0;
		end else begin
			grant_q         <= cmd_bus_grant;
			mem_alfull_q    <= mem_alfull;
			cmd_bus_request <= enabled && !buf_empty && !mem_alfull;
			cmd_out_valid   <= bus_pop;
		end
	end

	always_ff @(posedge clock) begin
		if (bus_pop)
			{cmd_out_cu, cmd_out_addr} <= buf_out;
	end

endmodule

/* response_router.sv */
`timescale 1ns/1ps

module response_router (
	input  logic                                                clock,
	input  logic                                                rstn,
	input  logic                                                rsp_valid,
	input  pagerank_pkg::cu_id_t                                rsp_cu,
	input  pagerank_pkg::rsp_data_t                             rsp_data,
	output pagerank_pkg::cu_mask_t                              cu_rsp_valid,
	output pagerank_pkg::rsp_data_t [pagerank_pkg::NUM_CU-1:0]  cu_rsp_data
);

	logic                    rsp_valid_q;
	pagerank_pkg::cu_id_t    rsp_cu_q;
	pagerank_pkg::rsp_data_t rsp_data_q;

	// Input stage, then one-hot decode
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rsp_valid_q  <= 1'b0;
			cu_rsp_valid <= '0;
		end else begin
			rsp_valid_q  <= rsp_valid;
			cu_rsp_valid <= rsp_valid_q ? (pagerank_pkg::cu_mask_t'(1) << rsp_cu_q) : '0;
		end
	end

	always_ff @(posedge clock) begin
		rsp_cu_q   <= rsp_cu;
		rsp_data_q <= rsp_data;
		for (int i = 0; i < pagerank_pkg::NUM_CU; i++) begin
			if (rsp_valid_q && rsp_cu_q == pagerank_pkg::cu_id_t'(i))
				cu_rsp_data[i] <= rsp_data_q;
		end
	end

endmodule

/* vertex_count_reduce.sv */
`timescale 1ns/1ps

module vertex_count_reduce (
	input  logic                                             clock,
	input  logic                                             rstn,
	input  pagerank_pkg::count_t [pagerank_pkg::NUM_CU-1:0]  cu_vertex_count,
	output pagerank_pkg::count_t                             vertex_done_count
);

	pagerank_pkg::count_t [pagerank_pkg::NUM_CU-1:0] count_q;
	pagerank_pkg::count_t                            count_sum;

	// Wraps at the counter width
	always_comb begin
		count_sum = '0;
		for (int i = 0; i < pagerank_pkg::NUM_CU; i++)
			count_sum = count_sum + count_q[i];
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			count_q           <= '0;
			vertex_done_count <= '0;
		end else begin
			count_q           <= cu_vertex_count;
			vertex_done_count <= count_sum;
		end
	end

endmodule

/* vertex_arbiter_control.sv */
`timescale 1ns/1ps

module vertex_arbiter_control (
	input  logic                                                clock,
	input  logic                                                rstn,
	input  logic                                                enabled_in,
	input  logic                                                job_valid,
	input  pagerank_pkg::vertex_t                               job_vertex,
	output logic                                                job_request,
	input  pagerank_pkg::cu_mask_t                              cu_job_request,
	output pagerank_pkg::cu_mask_t                              cu_job_valid,
	output pagerank_pkg::vertex_t [pagerank_pkg::NUM_CU-1:0]    cu_job_vertex,
	input  pagerank_pkg::cu_mask_t                              cu_cmd_request,
	input  pagerank_pkg::addr_t [pagerank_pkg::NUM_CU-1:0]      cu_cmd_addr,
	output pagerank_pkg::cu_mask_t                              cu_cmd_ready,
	input  logic                                                mem_alfull,
	input  logic                                                cmd_bus_grant,
	output logic                                                cmd_bus_request,
	output logic                                                cmd_out_valid,
	output pagerank_pkg::cu_id_t                                cmd_out_cu,
	output pagerank_pkg::addr_t                                 cmd_out_addr,
	input  logic                                                rsp_valid,
	input  pagerank_pkg::cu_id_t                                rsp_cu,
	input  pagerank_pkg::rsp_data_t                             rsp_data,
	output pagerank_pkg::cu_mask_t                              cu_rsp_valid,
	output pagerank_pkg::rsp_data_t [pagerank_pkg::NUM_CU-1:0]  cu_rsp_data,
	input  pagerank_pkg::count_t [pagerank_pkg::NUM_CU-1:0]     cu_vertex_count,
	output pagerank_pkg::count_t                                vertex_done_count
);

	logic enabled;

	read_cmd_if read_cmd ();

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			enabled <= 1'b0;
		else
			enabled <= enabled_in;
	end

	//////////////////////////////////////////////////
	// Jobs out, commands in
	//////////////////////////////////////////////////

	vertex_job_dispatch vertex_job_dispatch_i (
		.clock         (clock),
		.rstn          (rstn),
		.enabled       (enabled),
		.job_valid     (job_valid),
		.job_vertex    (job_vertex),
		.job_request   (job_request),
		.cu_job_request(cu_job_request),
		.cu_job_valid  (cu_job_valid),
		.cu_job_vertex (cu_job_vertex)
	);

	read_cmd_arbiter read_cmd_arbiter_i (
		.clock         (clock),
		.rstn          (rstn),
		.enabled       (enabled),
		.cu_cmd_request(cu_cmd_request),
		.cu_cmd_addr   (cu_cmd_addr),
		.cu_cmd_ready  (cu_cmd_ready),
		.cmd           (read_cmd.arbiter)
	);

	cmd_bus_issue cmd_bus_issue_i (
		.clock          (clock),
		.rstn           (rstn),
		.enabled        (enabled),
		.cmd            (read_cmd.buffer),
		.mem_alfull     (mem_alfull),
		.cmd_bus_grant  (cmd_bus_grant),
		.cmd_bus_request(cmd_bus_request),
		.cmd_out_valid  (cmd_out_valid),
		.cmd_out_cu     (cmd_out_cu),
		.cmd_out_addr   (cmd_out_addr)
	);

	//////////////////////////////////////////////////
	// Responses and counters, not gated by enable
	//////////////////////////////////////////////////

	response_router response_router_i (
		.clock       (clock),
		.rstn        (rstn),
		.rsp_valid   (rsp_valid),
		.rsp_cu      (rsp_cu),
		.rsp_data    (rsp_data),
		.cu_rsp_valid(cu_rsp_valid),
		.cu_rsp_data (cu_rsp_data)
	);

	vertex_count_reduce vertex_count_reduce_i (
		.clock            (clock),
		.rstn             (rstn),
		.cu_vertex_count  (cu_vertex_count),
		.vertex_done_count(vertex_done_count)
	);

endmodule

/* vertex_arbiter_control_props.sv */
`timescale 1ns/1ps

module vertex_arbiter_control_props (
	input logic                   clock,
	input logic                   rstn,
	input pagerank_pkg::cu_mask_t cu_job_valid,
	input pagerank_pkg::cu_mask_t cu_cmd_ready,
	input pagerank_pkg::cu_mask_t cu_rsp_valid,
	input logic                   cmd_bus_grant,
	input logic                   cmd_out_valid
);

	// One unit at most per cycle on each path
	job_valid_onehot: assert property (@(posedge clock) disable iff (!rstn)
		$onehot0(cu_job_valid)) else $error("cu_job_valid has more than one bit set");

	cmd_ready_onehot: assert property (@(posedge clock) disable iff (!rstn)
		$onehot0(cu_cmd_ready)) else $error("cu_cmd_ready has more than one bit set");

	rsp_valid_onehot: assert property (@(posedge clock) disable iff (!rstn)
		$onehot0(cu_rsp_valid)) else $error("cu_rsp_valid has more than one bit set");

	// Grant, registered grant, then the popped entry
	issue_after_grant: assert property (@(posedge clock) disable iff (!rstn)
		cmd_out_valid |-> $past(cmd_bus_grant, 2))
		else $error("cmd_out_valid without a grant two cycles before");

endmodule

bind vertex_arbiter_control vertex_arbiter_control_props vertex_arbiter_control_props_i (.*);

/* vertex_arbiter_control_tb.sv */
`timescale 1ns/1ps

module vertex_arbiter_control_tb;

	logic                                               clock = 1'b0;
	logic                                               rstn;
	logic                                               enabled_in;
	logic                                               job_valid;
	pagerank_pkg::vertex_t                              job_vertex;
	logic                                               job_request;
	pagerank_pkg::cu_mask_t                             cu_job_request;
	pagerank_pkg::cu_mask_t                             cu_job_valid;
	pagerank_pkg::vertex_t [pagerank_pkg::NUM_CU-1:0]   cu_job_vertex;
	pagerank_pkg::cu_mask_t                             cu_cmd_request = '0;
	pagerank_pkg::addr_t [pagerank_pkg::NUM_CU-1:0]     cu_cmd_addr = '0;
	pagerank_pkg::cu_mask_t                             cu_cmd_ready;
	logic                                               mem_alfull;
	logic                                               cmd_bus_grant = 1'b0;
	logic                                               cmd_bus_request;
	logic                                               cmd_out_valid;
	pagerank_pkg::cu_id_t                               cmd_out_cu;
	pagerank_pkg::addr_t                                cmd_out_addr;
	logic                                               rsp_valid;
	pagerank_pkg::cu_id_t                               rsp_cu;
	pagerank_pkg::rsp_data_t                            rsp_data;
	pagerank_pkg::cu_mask_t                             cu_rsp_valid;
	pagerank_pkg::rsp_data_t [pagerank_pkg::NUM_CU-1:0] cu_rsp_data;
	pagerank_pkg::count_t [pagerank_pkg::NUM_CU-1:0]    cu_vertex_count;
	pagerank_pkg::count_t                               vertex_done_count;

	// Records and scoreboards
	string                   records[$];
	int                      n_records = 0;
	pagerank_pkg::vertex_t   job_exp_vertex[$];
	pagerank_pkg::cu_id_t    job_exp_cu[$];
	int                      job_asked[pagerank_pkg::NUM_CU];
	int                      job_served[pagerank_pkg::NUM_CU];
	pagerank_pkg::addr_t     cmd_todo[pagerank_pkg::NUM_CU][$];
	pagerank_pkg::addr_t     cmd_exp[pagerank_pkg::NUM_CU][$];
	logic [1:0]              en_hist = 2'b00;
	logic [1:0]              alf_hist = 2'b00;
	logic [1:0]              rsp_v_hist = 2'b00;
	pagerank_pkg::cu_id_t    rsp_cu_hist[2];
	pagerank_pkg::rsp_data_t rsp_data_hist[2];
	logic [31:0]             rnd_state = 32'd87;
	int                      grant_gap = 0;

	vertex_arbiter_control vertex_arbiter_control_i (.*);

	always #10 clock = ~clock;

	//////////////////////////////////////////////////
	// Failure reporting and compare tasks
	//////////////////////////////////////////////////

	task automatic stop_run(string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check_vertex(string name, pagerank_pkg::vertex_t got,
			pagerank_pkg::vertex_t exp);
		if (got !== exp)
			stop_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_cu(string name, pagerank_pkg::cu_id_t got, pagerank_pkg::cu_id_t exp);
		if (got !== exp)
			stop_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_addr(string name, pagerank_pkg::addr_t got, pagerank_pkg::addr_t exp);
		if (got !== exp)
			stop_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_data(string name, pagerank_pkg::rsp_data_t got,
			pagerank_pkg::rsp_data_t exp);
		if (got !== exp)
			stop_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_count(string name, pagerank_pkg::count_t got,
			pagerank_pkg::count_t exp);
		if (got !== exp)
			stop_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_mask(string name, pagerank_pkg::cu_mask_t got,
			pagerank_pkg::cu_mask_t exp);
		if (got !== exp)
			stop_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
	endtask

	// Jobs leave in push order, only to a unit still waiting
	task automatic check_job();
		pagerank_pkg::cu_id_t unit;
		unit = '0;
		for (int u = 0; u < pagerank_pkg::NUM_CU; u++)
			if (cu_job_valid[u])
				unit = pagerank_pkg::cu_id_t'(u);
		if (job_exp_cu.size() == 0) begin
			stop_run("a job was handed out that was never pushed");
		end else begin
			check_cu("job unit", unit, job_exp_cu.pop_front());
			check_vertex("cu_job_vertex", cu_job_vertex[unit], job_exp_vertex.pop_front());
			if (job_asked[unit] <= job_served[unit])
				stop_run("a job went to a unit with no open request");
			job_served[unit]++;
		end
	endtask

	// Addresses are unique per unit, so the head match names the unit
	task automatic check_cmd();
		int unit;
		unit = -1;
		for (int u = 0; u < pagerank_pkg::NUM_CU; u++)
			if (cmd_exp[u].size() != 0 && cmd_exp[u][0] == cmd_out_addr)
				unit = u;
		if (unit < 0) begin
			stop_run("a command came out that no unit has next in its queue");
		end else begin
			check_cu("cmd_out_cu", cmd_out_cu, pagerank_pkg::cu_id_t'(unit));
			check_addr("cmd_out_addr", cmd_out_addr, cmd_exp[unit].pop_front());
		end
	endtask

	function automatic logic [31:0] xorshift(logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic bit cmds_drained();
		for (int u = 0; u < pagerank_pkg::NUM_CU; u++)
			if (cmd_todo[u].size() != 0 || cmd_exp[u].size() != 0)
				return 1'b0;
		return 1'b1;
	endfunction

	function automatic int jobs_open();
		int open;
		open = 0;
		for (int u = 0; u < pagerank_pkg::NUM_CU; u++)
			open = open + job_asked[u] - job_served[u];
		return open;
	endfunction

	//////////////////////////////////////////////////
	// Unit and memory bus models
	//////////////////////////////////////////////////

	// Each unit holds its command until it sees its ready
	always @(negedge clock) begin
		for (int u = 0; u < pagerank_pkg::NUM_CU; u++) begin
			if (cu_cmd_request[u] && cu_cmd_ready[u]) begin
				cu_cmd_request[u] = 1'b0;
			end else if (!cu_cmd_request[u] && cmd_todo[u].size() != 0) begin
				cu_cmd_addr[u] = cmd_todo[u].pop_front();
				cmd_exp[u].push_back(cu_cmd_addr[u]);
				cu_cmd_request[u] = 1'b1;
			end
		end
	end

	// Grants only while the request is seen, random spacing
	always @(negedge clock) begin
		cmd_bus_grant = 1'b0;
		if (grant_gap > 0) begin
			grant_gap--;
		end else if (cmd_bus_request) begin
			cmd_bus_grant = 1'b1;
			rnd_state = xorshift(rnd_state);
			grant_gap = int'(rnd_state % 3);
		end
	end

	// Input history for the latency and gating rules
	always @(posedge clock) begin
		en_hist          <= {en_hist[0], enabled_in};
		alf_hist         <= {alf_hist[0], mem_alfull};
		rsp_v_hist       <= {rsp_v_hist[0], rsp_valid};
		rsp_cu_hist[1]   <= rsp_cu_hist[0];
		rsp_cu_hist[0]   <= rsp_cu;
		rsp_data_hist[1] <= rsp_data_hist[0];
		rsp_data_hist[0] <= rsp_data;
	end

	always @(negedge clock) begin
		if (rstn) begin
			if (en_hist == 2'b00) begin
				check_mask("cu_job_valid", cu_job_valid, '0);
				check_mask("cu_cmd_ready", cu_cmd_ready, '0);
				if (cmd_bus_request)
					stop_run("the bus request was raised while disabled");
			end
			if (alf_hist == 2'b11 && cmd_out_valid)
				stop_run("a command was issued under memory back-pressure");
			if (cu_job_valid != '0)
				check_job();
			if (cmd_out_valid)
				check_cmd();
			check_mask("cu_rsp_valid", cu_rsp_valid,
				rsp_v_hist[1] ? pagerank_pkg::cu_mask_t'(1) << rsp_cu_hist[1] : '0);
			if (rsp_v_hist[1])
				check_data("cu_rsp_data", cu_rsp_data[rsp_cu_hist[1]], rsp_data_hist[1]);
		end
	end

	initial begin
		wait (n_records > 0);
		repeat (n_records * 60) @(posedge clock);
		stop_run($sformatf("timeout after %0d cycles", n_records * 60));
	end

	//////////////////////////////////////////////////
	// Pattern reader and stimulus
	//////////////////////////////////////////////////

	initial begin
		int          fd;
		int          n;
		string       line;
		byte         kind;
		logic [31:0] f[5];
		rstn            = 1'b0;
		enabled_in      = 1'b0;
		job_valid       = 1'b0;
		job_vertex      = '0;
		cu_job_request  = '0;
		mem_alfull      = 1'b0;
		rsp_valid       = 1'b0;
		rsp_cu          = '0;
		rsp_data        = '0;
		cu_vertex_count = '0;
		fd = $fopen("vertex_arbiter_patterns.txt", "r");
		if (fd == 0)
			stop_run("cannot open vertex_arbiter_patterns.txt");
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 1 && line.getc(0) != "#")
				records.push_back(line);
		end
		$fclose(fd);
		if (records.size() == 0)
			stop_run("the pattern file holds no records");
		n_records = records.size();
		repeat (3) @(posedge clock);
		@(negedge clock);
		rstn = 1'b1;
		foreach (records[i]) begin
			line = records[i];
			kind = line.getc(0);
			for (int k = 0; k < 5; k++)
				f[k] = '0;
			n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h",
				f[0], f[1], f[2], f[3], f[4]);
			@(negedge clock);
			job_valid      = 1'b0;
			cu_job_request = '0;
			rsp_valid      = 1'b0;
			case (kind)
				"J": begin
					while (!job_request)
						@(negedge clock);
					job_valid  = 1'b1;
					job_vertex = pagerank_pkg::vertex_t'(f[0]);
					job_exp_vertex.push_back(pagerank_pkg::vertex_t'(f[0]));
					job_exp_cu.push_back(pagerank_pkg::cu_id_t'(f[1]));
				end
				"Q": begin
					cu_job_request = pagerank_pkg::cu_mask_t'(f[0]);
					for (int u = 0; u < pagerank_pkg::NUM_CU; u++)
						if (f[0][u])
							job_asked[u]++;
				end
				"C": cmd_todo[int'(f[0])].push_back(pagerank_pkg::addr_t'(f[1]));
				"R": begin
					rsp_valid = 1'b1;
					rsp_cu    = pagerank_pkg::cu_id_t'(f[0]);
					rsp_data  = pagerank_pkg::rsp_data_t'(f[1]);
				end
				"S": begin
					for (int u = 0; u < pagerank_pkg::NUM_CU; u++)
						cu_vertex_count[u] = pagerank_pkg::count_t'(f[u]);
					repeat (2) @(negedge clock);
					check_count("vertex_done_count", vertex_done_count,
						pagerank_pkg::count_t'(f[4]));
				end
				"B": begin
					mem_alfull = 1'b1;
					repeat (int'(f[0])) @(negedge clock);
					mem_alfull = 1'b0;
				end
				"E": enabled_in = f[0][0];
				default: stop_run({"unknown record in pattern file: ", line});
			endcase
		end
		@(negedge clock);
		job_valid      = 1'b0;
		cu_job_request = '0;
		rsp_valid      = 1'b0;
		// Let held jobs and commands drain
		while (job_exp_cu.size() != 0 || !cmds_drained())
			@(negedge clock);
		repeat (4) @(negedge clock);
		if (jobs_open() != 0) begin
			stop_run("job requests were left unserved");
		end else begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule

/* vertex_arbiter_patterns.txt */
# J vertex unit | Q mask | C unit addr | R unit data | S c0 c1 c2 c3 sum
# B cycles | E enable ; all fields hex
E 1
Q f
J 0011 0
J 0022 1
J 0033 2
J 0044 3
C 0 00001000
C 1 00002000
C 2 00003000
C 3 00004000
C 0 00001040
C 1 00002040
C 2 00003040
C 3 00004040
B c
R 2 cafe0001
R 0 cafe0002
R 3 cafe0003
S 0001 0002 0003 0004 000a
E 0
Q 5
J 0055 0
J 0066 2
C 1 00002080
R 1 beef0004
S ffff 0001 1000 0200 1200
E 1
S 0010 0020 0030 0040 00a0

/* all.f */
pagerank_pkg.sv
read_cmd_if.sv
job_fifo.sv
vertex_job_dispatch.sv
read_cmd_arbiter.sv
cmd_bus_issue.sv
response_router.sv
vertex_count_reduce.sv
vertex_arbiter_control.sv
vertex_arbiter_control_props.sv
vertex_arbiter_control_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= vertex_arbiter_control_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

.PHONY: sim clean
